// ==== include/fabric_defs.svh ====
//------------------------------
// Fabric widths, region codes, register offsets
// and fixed read values
//------------------------------
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// Bus widths
`define FAB_ADDR_W      17
`define FAB_DATA_W      32
`define FAB_REGION_W    4
`define FAB_REG_ADDR_W  7
`define FAB_RAM_ADDR_W  11

// Region codes, address bits 16 to 13
`define REGION_REGS     4'd0
`define REGION_RAM0     4'd1
`define REGION_RESERVED 4'd6

// Register word offsets
`define REG_ID          7'h00
`define REG_REV         7'h01
`define REG_GPIO_IN     7'h02
`define REG_GPIO_OUT    7'h03
`define REG_GPIO_OE     7'h04
`define REG_CLK_CNTL    7'h05

// Reserved block word offsets
`define RSV_CUST_PROD   7'h7E
`define RSV_REVISIONS   7'h7F

// Fixed read values
`define FAB_ID_VALUE        32'h0000_FAB1
`define FAB_REV_VALUE       32'h0000_0100
`define RSV_CUST_PROD_VALUE 32'h0000_0100
`define RSV_REVISIONS_VALUE 32'h0001_0000
`define REG_DEFAULT_VALUE   32'hFABD_EFAC
`define RSV_DEFAULT_VALUE   32'hDEFF_ABAC
`define BAD_ACCESS_VALUE    32'hBADF_ABAC

// Misc
`define TIMEOUT_CYCLES  7
`define GPIO_W          8

`endif

// ==== hdl/fabricPkg.sv ====
//------------------------------
// Address union and region enumeration
//------------------------------
`default_nettype none

`include "fabric_defs.svh"

package fabricPkg;

    // Register and reserved block view of the byte address
    typedef struct packed {
        logic [`FAB_REGION_W-1:0]   region;
        logic [3:0]                 unused;
        logic [`FAB_REG_ADDR_W-1:0] wordOff;
        logic [1:0]                 byteSel;
    } regView_t;

    // RAM view, word address spans the whole region
    typedef struct packed {
        logic [`FAB_REGION_W-1:0]   region;
        logic [`FAB_RAM_ADDR_W-1:0] wordAddr;
        logic [1:0]                 byteSel;
    } ramView_t;

    // Same 17 bits, two decodes
    typedef union packed {
        regView_t regView;
        ramView_t ramView;
    } fabricAddr_t;

    //------------------------------
    // Region codes
    //------------------------------
    typedef enum logic [`FAB_REGION_W-1:0] {
        RGN_REGS     = `REGION_REGS,
        RGN_RAM0     = `REGION_RAM0,
        RGN_RESERVED = `REGION_RESERVED
    } region_t;

endpackage

`default_nettype wire

// ==== hdl/busDecoder.sv ====
//------------------------------
// Region decode, read-data merge, ack merge
//------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "fabric_defs.svh"

module busDecoder (
    // Host side
    input  wire logic [`FAB_ADDR_W-1:0] wbAdr_i,
    input  wire logic                   wbCyc_i,

    // Target responses
    input  wire logic [`FAB_DATA_W-1:0] regDat_i,
    input  wire logic                   regAck_i,
    input  wire logic [`FAB_DATA_W-1:0] ramDat_i,
    input  wire logic                   ramAck_i,
    input  wire logic [`FAB_DATA_W-1:0] rsvDat_i,
    input  wire logic                   rsvAck_i,

    // Target selects
    output logic                        regCyc_o,
    output logic                        ramCyc_o,
    output logic                        rsvCyc_o,

    // Merged response
    output logic [`FAB_DATA_W-1:0]      wbRdDat_o,
    output logic                        wbAck_o
);

    fabricPkg::fabricAddr_t adr;
    fabricPkg::region_t     region;

    assign adr    = wbAdr_i;
    // Codes outside the enum fall to the default arm
    assign region = fabricPkg::region_t'(adr.regView.region);

    //------------------------------
    // Per-target cycle selects
    //------------------------------
    assign regCyc_o = wbCyc_i && (region == fabricPkg::RGN_REGS);
    assign ramCyc_o = wbCyc_i && (region == fabricPkg::RGN_RAM0);
    assign rsvCyc_o = wbCyc_i && (region == fabricPkg::RGN_RESERVED);

    //------------------------------
    // Read data by region
    //------------------------------
    always_comb
    begin
        case (region)
            fabricPkg::RGN_REGS:
            begin
                wbRdDat_o = regDat_i;
            end
            fabricPkg::RGN_RAM0:
            begin
                wbRdDat_o = ramDat_i;
            end
            fabricPkg::RGN_RESERVED:
            begin
                wbRdDat_o = rsvDat_i;
            end
            default:
            begin
                // Unmapped, timeout ack comes from the reserved block
                wbRdDat_o = `BAD_ACCESS_VALUE;
            end
        endcase
    end

    // Only one target acks per access
    assign wbAck_o = regAck_i | ramAck_i | rsvAck_i;

endmodule

`default_nettype wire

// ==== hdl/fabricRegisters.sv ====
//------------------------------
// ID, revision, GPIO and clock-control registers
//------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "fabric_defs.svh"

module fabricRegisters (
    input  wire logic                       wbClk_i,
    input  wire logic                       reset_i,
    input  wire logic [`FAB_ADDR_W-1:0]     wbAdr_i,
    input  wire logic                       wbCyc_i,
    input  wire logic                       wbStb_i,
    input  wire logic                       wbWe_i,
    input  wire logic [`FAB_DATA_W/8-1:0]   wbByteStb_i,
    input  wire logic [`FAB_DATA_W-1:0]     wbWrDat_i,
    input  wire logic [`GPIO_W-1:0]         gpioIn_i,
    output logic [`FAB_DATA_W-1:0]          wbDat_o,
    output logic                            wbAck_o,
    output logic [`GPIO_W-1:0]              gpioOut_o,
    output logic [`GPIO_W-1:0]              gpioOe_o,
    output logic                            clk4mCntl_o,
    output logic                            clk1mCntl_o
);

    fabricPkg::fabricAddr_t     adr;
    logic [`FAB_REG_ADDR_W-1:0] wordOff;
    logic                       request;
    logic                       wrLow;
    logic [`GPIO_W-1:0]         gpioMeta;
    logic [`GPIO_W-1:0]         gpioSync;

    assign adr     = wbAdr_i;
    assign wordOff = adr.regView.wordOff;

    // New request, suppressed while ack is out
    assign request = wbCyc_i && wbStb_i && !wbAck_o;
    // Low byte write
    assign wrLow   = request && wbWe_i && wbByteStb_i[0];

    //------------------------------
    // Ack and writable registers
    //------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (reset_i)
        begin
            wbAck_o     <= 1'b0;
            gpioOut_o   <= '0;
            gpioOe_o    <= '0;
            clk4mCntl_o <= 1'b0;
            clk1mCntl_o <= 1'b0;
        end
        else
        begin
            wbAck_o <= request;
            if (wrLow && (wordOff == `REG_GPIO_OUT))
            begin
                gpioOut_o <= wbWrDat_i[`GPIO_W-1:0];
            end
            if (wrLow && (wordOff == `REG_GPIO_OE))
            begin
                gpioOe_o <= wbWrDat_i[`GPIO_W-1:0];
            end
            if (wrLow && (wordOff == `REG_CLK_CNTL))
            begin
                clk4mCntl_o <= wbWrDat_i[0];
                clk1mCntl_o <= wbWrDat_i[1];
            end
        end
    end

    // Two-stage sampler on the GPIO inputs
    always_ff @(posedge wbClk_i)
    begin
        gpioMeta <= gpioIn_i;
        gpioSync <= gpioMeta;
    end

    //------------------------------
    // Read mux
    //------------------------------
    always_comb
    begin
        case (wordOff)
            `REG_ID:       wbDat_o = `FAB_ID_VALUE;
            `REG_REV:      wbDat_o = `FAB_REV_VALUE;
            `REG_GPIO_IN:  wbDat_o = {{(`FAB_DATA_W-`GPIO_W){1'b0}}, gpioSync};
            `REG_GPIO_OUT: wbDat_o = {{(`FAB_DATA_W-`GPIO_W){1'b0}}, gpioOut_o};
            `REG_GPIO_OE:  wbDat_o = {{(`FAB_DATA_W-`GPIO_W){1'b0}}, gpioOe_o};
            `REG_CLK_CNTL: wbDat_o = {{(`FAB_DATA_W-2){1'b0}}, clk1mCntl_o, clk4mCntl_o};
            default:       wbDat_o = `REG_DEFAULT_VALUE;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/scratchRam.sv ====
//------------------------------
// Scratch RAM, 2048 x 32, byte strobes
//------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "fabric_defs.svh"

module scratchRam (
    input  wire logic                       wbClk_i,
    input  wire logic [`FAB_ADDR_W-1:0]     wbAdr_i,
    input  wire logic                       wbCyc_i,
    input  wire logic                       wbStb_i,
    input  wire logic                       wbWe_i,
    input  wire logic [`FAB_DATA_W/8-1:0]   wbByteStb_i,
    input  wire logic [`FAB_DATA_W-1:0]     wbWrDat_i,
    input  wire logic                       reset_i,
    output logic [`FAB_DATA_W-1:0]          wbDat_o,
    output logic                            wbAck_o
);

    fabricPkg::fabricAddr_t     adr;
    logic [`FAB_RAM_ADDR_W-1:0] wordAddr;
    logic                       request;
    logic [`FAB_DATA_W-1:0]     mem [0:(1<<`FAB_RAM_ADDR_W)-1];

    assign adr      = wbAdr_i;
    assign wordAddr = adr.ramView.wordAddr;
    assign request  = wbCyc_i && wbStb_i && !wbAck_o;

    //------------------------------
    // Array, per-lane write
    //------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (request && wbWe_i)
        begin
            for (int lane = 0; lane < `FAB_DATA_W/8; lane++)
            begin
                if (wbByteStb_i[lane])
                begin
                    mem[wordAddr][8*lane +: 8] <= wbWrDat_i[8*lane +: 8];
                end
            end
        end
        // Registered read, lands together with ack
        wbDat_o <= mem[wordAddr];
    end

    // One pulse per request
    always_ff @(posedge wbClk_i)
    begin
        if (reset_i)
        begin
            wbAck_o <= 1'b0;
        end
        else
        begin
            wbAck_o <= request;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reservedBlock.sv ====
//------------------------------
// Identity words and access timeout
//------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "fabric_defs.svh"

module reservedBlock (
    input  wire logic                   wbClk_i,
    input  wire logic                   reset_i,
    input  wire logic [`FAB_ADDR_W-1:0] wbAdr_i,
    input  wire logic                   rsvCyc_i,
    input  wire logic                   wbCyc_i,
    input  wire logic                   wbStb_i,
    input  wire logic                   wbAck_i,
    output logic [`FAB_DATA_W-1:0]      wbDat_o,
    output logic                        wbAck_o
);

    fabricPkg::fabricAddr_t adr;
    logic                   rsvRequest;
    logic                   pending;
    logic                   timeoutHit;
    logic [2:0]             timeoutCnt;

    assign adr        = wbAdr_i;
    assign rsvRequest = rsvCyc_i && wbStb_i && !wbAck_o;

    // Any cycle on the bus still waiting for a target
    assign pending    = wbCyc_i && wbStb_i && !wbAck_i;
    assign timeoutHit = pending && (timeoutCnt == 3'(`TIMEOUT_CYCLES));

    //------------------------------
    // Timeout counter and ack
    //------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (reset_i)
        begin
            timeoutCnt <= '0;
            wbAck_o    <= 1'b0;
        end
        else
        begin
            // Own registers or the timeout, never both
            wbAck_o <= rsvRequest || timeoutHit;
            if (!pending || timeoutHit)
            begin
                timeoutCnt <= '0;
            end
            else
            begin
                timeoutCnt <= timeoutCnt + 3'd1;
            end
        end
    end

    // Read mux, word offset only
    always_comb
    begin
        case (adr.regView.wordOff)
            `RSV_CUST_PROD: wbDat_o = `RSV_CUST_PROD_VALUE;
            `RSV_REVISIONS: wbDat_o = `RSV_REVISIONS_VALUE;
            default:        wbDat_o = `RSV_DEFAULT_VALUE;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/fabricTop.sv ====
//------------------------------
// Fabric top, decoder and three targets
//------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "fabric_defs.svh"

module fabricTop (
    input  wire logic                       wbClk_i,
    input  wire logic                       reset_i,
    input  wire logic [`FAB_ADDR_W-1:0]     wbAdr_i,
    input  wire logic                       wbCyc_i,
    input  wire logic                       wbStb_i,
    input  wire logic                       wbWe_i,
    input  wire logic [`FAB_DATA_W/8-1:0]   wbByteStb_i,
    input  wire logic [`FAB_DATA_W-1:0]     wbWrDat_i,
    input  wire logic [`GPIO_W-1:0]         gpioIn_i,
    output logic [`FAB_DATA_W-1:0]          wbRdDat_o,
    output logic                            wbAck_o,
    output logic [`GPIO_W-1:0]              gpioOut_o,
    output logic [`GPIO_W-1:0]              gpioOe_o,
    output logic                            clk4mCntl_o,
    output logic                            clk1mCntl_o
);

    // Target selects
    logic                   regCyc;
    logic                   ramCyc;
    logic                   rsvCyc;

    // Target responses
    logic [`FAB_DATA_W-1:0] regDat;
    logic [`FAB_DATA_W-1:0] ramDat;
    logic [`FAB_DATA_W-1:0] rsvDat;
    logic                   regAck;
    logic                   ramAck;
    logic                   rsvAck;

    //------------------------------
    // Decode and merge
    //------------------------------
    busDecoder uDecoder (
        .wbAdr_i   (wbAdr_i),
        .wbCyc_i   (wbCyc_i),
        .regDat_i  (regDat),
        .regAck_i  (regAck),
        .ramDat_i  (ramDat),
        .ramAck_i  (ramAck),
        .rsvDat_i  (rsvDat),
        .rsvAck_i  (rsvAck),
        .regCyc_o  (regCyc),
        .ramCyc_o  (ramCyc),
        .rsvCyc_o  (rsvCyc),
        .wbRdDat_o (wbRdDat_o),
        .wbAck_o   (wbAck_o)
    );

    //------------------------------
    // Targets
    //------------------------------
    fabricRegisters uRegisters (
        .wbClk_i     (wbClk_i),
        .reset_i     (reset_i),
        .wbAdr_i     (wbAdr_i),
        .wbCyc_i     (regCyc),
        .wbStb_i     (wbStb_i),
        .wbWe_i      (wbWe_i),
        .wbByteStb_i (wbByteStb_i),
        .wbWrDat_i   (wbWrDat_i),
        .gpioIn_i    (gpioIn_i),
        .wbDat_o     (regDat),
        .wbAck_o     (regAck),
        .gpioOut_o   (gpioOut_o),
        .gpioOe_o    (gpioOe_o),
        .clk4mCntl_o (clk4mCntl_o),
        .clk1mCntl_o (clk1mCntl_o)
    );

    scratchRam uRam0 (
        .wbClk_i     (wbClk_i),
        .wbAdr_i     (wbAdr_i),
        .wbCyc_i     (ramCyc),
        .wbStb_i     (wbStb_i),
        .wbWe_i      (wbWe_i),
        .wbByteStb_i (wbByteStb_i),
        .wbWrDat_i   (wbWrDat_i),
        .reset_i     (reset_i),
        .wbDat_o     (ramDat),
        .wbAck_o     (ramAck)
    );

    // Sees the global cycle and merged ack for the timeout
    reservedBlock uReserved (
        .wbClk_i  (wbClk_i),
        .reset_i  (reset_i),
        .wbAdr_i  (wbAdr_i),
        .rsvCyc_i (rsvCyc),
        .wbCyc_i  (wbCyc_i),
        .wbStb_i  (wbStb_i),
        .wbAck_i  (wbAck_o),
        .wbDat_o  (rsvDat),
        .wbAck_o  (rsvAck)
    );

endmodule

`default_nettype wire

// ==== tests/fabricTb.sv ====
//------------------------------
// Fabric testbench with bus tasks, LFSR stimulus,
// assertions, watchdog and report
//------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "fabric_defs.svh"

module fabricTb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int ACK_LIMIT     = 16;
    // Watchdog budget from accesses times worst access length times margin
    localparam int ACCESS_BUDGET = 150;
    localparam int WORST_CYCLES  = 12;
    localparam int MARGIN        = 3;
    localparam int RAM_ROUNDS    = 24;

    logic                         wbClk;
    logic                         reset;
    logic [`FAB_ADDR_W-1:0]       wbAdr;
    logic                         wbCyc;
    logic                         wbStb;
    logic                         wbWe;
    logic [`FAB_DATA_W/8-1:0]     wbByteStb;
    logic [`FAB_DATA_W-1:0]       wbWrDat;
    logic [`GPIO_W-1:0]           gpioIn;
    logic [`FAB_DATA_W-1:0]       wbRdDat;
    logic                         wbAck;
    logic [`GPIO_W-1:0]           gpioOut;
    logic [`GPIO_W-1:0]           gpioOe;
    logic                         clk4mCntl;
    logic                         clk1mCntl;
    logic                         mapped;

    int                           errors = 0;
    int                           errMark = 0;
    int                           testCount = 0;
    int                           failedTests = 0;
    logic [31:0]                  lfsrState = 32'h346ff6ce;
    logic [`FAB_DATA_W-1:0]       ramModel [0:(1<<`FAB_RAM_ADDR_W)-1];
    bit                           ramKnown [0:(1<<`FAB_RAM_ADDR_W)-1];

    fabricTop DUT (
        .wbClk_i     (wbClk),
        .reset_i     (reset),
        .wbAdr_i     (wbAdr),
        .wbCyc_i     (wbCyc),
        .wbStb_i     (wbStb),
        .wbWe_i      (wbWe),
        .wbByteStb_i (wbByteStb),
        .wbWrDat_i   (wbWrDat),
        .gpioIn_i    (gpioIn),
        .wbRdDat_o   (wbRdDat),
        .wbAck_o     (wbAck),
        .gpioOut_o   (gpioOut),
        .gpioOe_o    (gpioOe),
        .clk4mCntl_o (clk4mCntl),
        .clk1mCntl_o (clk1mCntl)
    );

    initial
    begin
        wbClk = 1'b0;
        forever #(CLK_PERIOD/2) wbClk = ~wbClk;
    end

    initial
    begin
        #(CLK_PERIOD * (RESET_CYCLES + ACCESS_BUDGET * WORST_CYCLES * MARGIN));
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    //------------------------------
    // Bus timing checks
    //------------------------------
    // Regions 0, 1 and 6 have a target behind them
    assign mapped = (wbAdr[16:13] == `REGION_REGS) || (wbAdr[16:13] == `REGION_RAM0)
                 || (wbAdr[16:13] == `REGION_RESERVED);

    ackPulse: assert property (@(posedge wbClk) disable iff (reset) wbAck |=> !wbAck)
    else
    begin
        $display("Acknowledge stayed high for more than one cycle");
        errors++;
    end
    ackInCycle: assert property (@(posedge wbClk) disable iff (reset) wbAck |-> wbCyc)
    else
    begin
        $display("Acknowledge seen without an open cycle");
        errors++;
    end
    // Mapped targets answer on the next edge
    mappedAck: assert property (@(posedge wbClk) disable iff (reset)
        ($rose(wbCyc) && mapped) |=> wbAck)
    else
    begin
        $display("Mapped access not acknowledged after one cycle");
        errors++;
    end
    // Timeout ack lands eight edges later
    unmappedAck: assert property (@(posedge wbClk) disable iff (reset)
        ($rose(wbCyc) && !mapped) |-> ##8 wbAck)
    else
    begin
        $display("Unmapped access not acknowledged after eight cycles");
        errors++;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrStep(lfsrState);
            val = {val[30:0], lfsrState[0]};
        end
    endtask

    // Word-aligned byte address from region and word offset
    function automatic logic [`FAB_ADDR_W-1:0] regAdr(input logic [3:0] rgn,
                                                     input logic [6:0] off);
        return {rgn, 4'b0000, off, 2'b00};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    //------------------------------
    // Bus access that waits for ack
    //------------------------------
    task automatic busAccess(input logic we, input logic [`FAB_ADDR_W-1:0] adr,
                             input logic [3:0] stb, input logic [31:0] wdat,
                             output logic [31:0] rdat, output int lat);
        @(posedge wbClk);
        wbAdr     <= adr;
        wbCyc     <= 1'b1;
        wbStb     <= 1'b1;
        wbWe      <= we;
        wbByteStb <= stb;
        wbWrDat   <= wdat;
        // Latency counted in edges after the request edge
        @(negedge wbClk);
        lat = 0;
        while (!wbAck && lat < ACK_LIMIT)
        begin
            @(negedge wbClk);
            lat++;
        end
        if (!wbAck)
        begin
            $display("No acknowledge for the access at address %h", adr);
            errors++;
        end
        rdat = wbRdDat;
        // Drop the request on the edge after ack
        @(posedge wbClk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
    endtask

    task automatic busWrite(input logic [`FAB_ADDR_W-1:0] adr, input logic [3:0] stb,
                            input logic [31:0] data);
        logic [31:0] unused;
        int          lat;
        busAccess(1'b1, adr, stb, data, unused, lat);
    endtask

    task automatic readCheck(input string name, input logic [`FAB_ADDR_W-1:0] adr,
                             input logic [31:0] exp, input int expLat);
        logic [31:0] rdat;
        int          lat;
        busAccess(1'b0, adr, 4'hF, '0, rdat, lat);
        checkValue(name, exp, rdat);
        checkValue({name, " latency"}, expLat, lat);
    endtask

    // Per-test summary line
    task automatic finishTest(input string name);
        if (errors == errMark)
        begin
            $display("Test %s: ok", name);
        end
        else
        begin
            $display("Test %s: %0d errors", name, errors - errMark);
            failedTests++;
        end
        errMark = errors;
        testCount++;
    endtask

    //------------------------------
    // Test sequence
    //------------------------------
    initial
    begin
        logic [31:0]              val;
        logic [31:0]              stb;
        logic [31:0]              wordAdr;
        logic [`FAB_ADDR_W-1:0]   adr;

        reset     = 1'b1;
        wbAdr     = '0;
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbByteStb = '0;
        wbWrDat   = '0;
        gpioIn    = '0;
        repeat (RESET_CYCLES) @(posedge wbClk);
        reset <= 1'b0;
        @(negedge wbClk);

        // Outputs idle and identity words readable
        checkValue("reset ack", 0, wbAck);
        checkValue("reset gpioOut", 0, gpioOut);
        checkValue("reset gpioOe", 0, gpioOe);
        checkValue("reset clkCntl", 0, {clk1mCntl, clk4mCntl});
        readCheck("id", regAdr(`REGION_REGS, `REG_ID), `FAB_ID_VALUE, 1);
        readCheck("rev", regAdr(`REGION_REGS, `REG_REV), `FAB_REV_VALUE, 1);
        readCheck("custProd", regAdr(`REGION_RESERVED, `RSV_CUST_PROD), `RSV_CUST_PROD_VALUE, 1);
        readCheck("revisions", regAdr(`REGION_RESERVED, `RSV_REVISIONS), `RSV_REVISIONS_VALUE, 1);
        finishTest("reset");

        // GPIO out and OE then a write without lane 0
        drawBits(`GPIO_W, val);
        busWrite(regAdr(`REGION_REGS, `REG_GPIO_OUT), 4'hF, val);
        @(negedge wbClk);
        checkValue("gpioOut pin", val, gpioOut);
        readCheck("gpioOut read", regAdr(`REGION_REGS, `REG_GPIO_OUT), val, 1);
        busWrite(regAdr(`REGION_REGS, `REG_GPIO_OUT), 4'b1110, ~val);
        readCheck("gpioOut masked", regAdr(`REGION_REGS, `REG_GPIO_OUT), val, 1);
        drawBits(`GPIO_W, val);
        busWrite(regAdr(`REGION_REGS, `REG_GPIO_OE), 4'h1, val);
        @(negedge wbClk);
        checkValue("gpioOe pin", val, gpioOe);
        readCheck("gpioOe read", regAdr(`REGION_REGS, `REG_GPIO_OE), val, 1);
        drawBits(`GPIO_W, val);
        @(posedge wbClk);
        gpioIn <= val[`GPIO_W-1:0];
        // Two sampling flops plus margin
        repeat (3) @(posedge wbClk);
        readCheck("gpioIn read", regAdr(`REGION_REGS, `REG_GPIO_IN), val, 1);
        finishTest("gpio");

        // Bit 0 drives the 4 MHz enable and bit 1 the 1 MHz enable
        for (int v = 1; v < 4; v++)
        begin
            busWrite(regAdr(`REGION_REGS, `REG_CLK_CNTL), 4'h1, v);
            @(negedge wbClk);
            checkValue("clkCntl pins", v, {clk1mCntl, clk4mCntl});
            readCheck("clkCntl read", regAdr(`REGION_REGS, `REG_CLK_CNTL), v, 1);
        end
        finishTest("clock");

        //------------------------------
        // Scratch RAM against a byte model
        //------------------------------
        for (int r = 0; r < RAM_ROUNDS; r++)
        begin
            drawBits(`FAB_RAM_ADDR_W, wordAdr);
            adr = {`REGION_RAM0, wordAdr[`FAB_RAM_ADDR_W-1:0], 2'b00};
            // Fill a fresh word first so every lane is known
            if (!ramKnown[wordAdr])
            begin
                drawBits(32, val);
                busWrite(adr, 4'hF, val);
                ramModel[wordAdr] = val;
                ramKnown[wordAdr] = 1'b1;
            end
            drawBits(32, val);
            drawBits(4, stb);
            busWrite(adr, stb[3:0], val);
            // Merge strobed lanes over the old word
            for (int lane = 0; lane < 4; lane++)
            begin
                if (stb[lane])
                begin
                    ramModel[wordAdr][8*lane +: 8] = val[8*lane +: 8];
                end
            end
            readCheck("ram read", adr, ramModel[wordAdr], 1);
        end
        finishTest("ram");

        readCheck("reg undefined", regAdr(`REGION_REGS, 7'h10), 32'hFABD_EFAC, 1);
        readCheck("rsv undefined", regAdr(`REGION_RESERVED, 7'h10), 32'hDEFF_ABAC, 1);
        finishTest("undefined");

        // Timeout path answers unmapped regions
        readCheck("unmapped", 17'h0E000, 32'hBADF_ABAC, 8);
        finishTest("unmapped");

        $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
hdl/fabricPkg.sv
hdl/busDecoder.sv
hdl/fabricRegisters.sv
hdl/scratchRam.sv
hdl/reservedBlock.sv
hdl/fabricTop.sv
tests/fabricTb.sv

// ==== Bender.yml ====
package:
  name: fabric

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/fabricPkg.sv
      - hdl/busDecoder.sv
      - hdl/fabricRegisters.sv
      - hdl/scratchRam.sv
      - hdl/reservedBlock.sv
      - hdl/fabricTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/fabricTb.sv
